// ==== nids_pkg.sv ====
package nids_pkg;

   // Payload byte width
   localparam int CHAR_W = 8;

   // Stream id width and the depth of each per-rule state memory
   localparam int STREAM_W    = 6;
   localparam int NUM_STREAMS = 64;

   // One enable bit per signature rule
   localparam int NUM_RULES = 2;

   // Matcher state holds a prefix length from 0 to PAT_LEN
   localparam int STATE_W = 3;
   localparam int PAT_LEN = 4;

   // Per-rule hit counters
   localparam int COUNT_W = 16;

   // Login command signatures, first character in the top byte
   // "USER"
   localparam logic [PAT_LEN*CHAR_W-1:0] PAT_USER = 32'h5553_4552;
   // "PASS"
   localparam logic [PAT_LEN*CHAR_W-1:0] PAT_PASS = 32'h5041_5353;

   // Packet sequencer FSM states
   typedef enum logic [2:0] {
      // Waiting for the first beat of a packet
      SEQ_IDLE,
      // Rule counters fetch the stream state
      SEQ_LOAD,
      // Matchers take the restored state
      SEQ_RESTORE,
      // Payload bytes accepted
      SEQ_SCAN,
      // Last accept strobe reaches the match flag
      SEQ_DRAIN,
      // Counters commit and state is saved
      SEQ_EOP
   } seq_state_t;

endpackage

// ==== pattern_dfa.sv ====
`timescale 1ns/1ps

module pattern_dfa
   import nids_pkg::*;
#(
   parameter logic [PAT_LEN*CHAR_W-1:0] PATTERN = PAT_USER
)
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic [CHAR_W-1:0]  char_in,
   input  logic               char_in_vld,
   input  logic [STATE_W-1:0] state_in,
   input  logic               state_in_vld,
   output logic [STATE_W-1:0] state_out,
   output logic               accept_out
);

   // Matched prefix length and the completion strobe
   logic [STATE_W-1:0] state_q;
   logic               accept_q;

   // Next-state helpers
   logic [STATE_W-1:0] base;
   logic [STATE_W-1:0] next_state;
   logic [CHAR_W-1:0]  expect_char;
   logic [CHAR_W-1:0]  first_char;

   // Top byte of the signature restarts a match
   assign first_char = PATTERN[PAT_LEN*CHAR_W-1 -: CHAR_W];

   always_comb
   begin
      // A full match continues as an empty prefix
      base = (state_q >= STATE_W'(PAT_LEN)) ? '0 : state_q;
      // Character that would extend the current prefix
      expect_char = PATTERN[(PAT_LEN - 1 - int'(base)) * CHAR_W +: CHAR_W];
      if (char_in == expect_char)
         next_state = base + 1'b1;
      else if (char_in == first_char)
         next_state = STATE_W'(1);
      else
         next_state = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q  <= '0;
         accept_q <= 1'b0;
      end
      else
      begin
         // Accept is a single-cycle strobe
         accept_q <= 1'b0;
         // Restored state wins over a character on the same edge
         if (state_in_vld)
            state_q <= state_in;
         else if (char_in_vld)
         begin
            state_q  <= next_state;
            accept_q <= (next_state == STATE_W'(PAT_LEN));
         end
      end
   end

   assign state_out  = state_q;
   assign accept_out = accept_q;

   // Restored states come from the rule memory and must stay in range too
   a_state_range: assert property (@(posedge clk) disable iff (!rst_n)
      state_q <= STATE_W'(PAT_LEN));

endmodule

// ==== stream_rule_counter.sv ====
`timescale 1ns/1ps

module stream_rule_counter
   import nids_pkg::*;
#(
   parameter logic [PAT_LEN*CHAR_W-1:0] PATTERN = PAT_USER
)
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic [CHAR_W-1:0]   char_in,
   input  logic                char_in_vld,
   input  logic                eop,
   input  logic                load_state,
   input  logic                enable,
   input  logic [STREAM_W-1:0] stream_id,
   input  logic                new_stream_id,
   output logic [COUNT_W-1:0]  count,
   output logic                fired
);

   // Saved matcher state, one entry per stream
   logic [STATE_W-1:0] state_mem [NUM_STREAMS];

   // Staged restore toward the matcher
   logic [STATE_W-1:0] state_in;
   logic               state_in_vld;

   // Matcher results
   logic [STATE_W-1:0] state_out;
   logic               accept_out;

   // Set by any match inside the current packet
   logic               spec_match;

   assign fired = spec_match;

   // Restore strobe lands one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   // New stream starts from an empty prefix, else pick up where it left off
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream_id)
            state_in <= '0;
         else
            state_in <= state_mem[stream_id];
      end
   end

   // Save state at end of packet only when this rule ran on it
   always_ff @(posedge clk)
   begin
      if (eop && enable)
         state_mem[stream_id] <= state_out;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count      <= '0;
         spec_match <= 1'b0;
      end
      else
      begin
         // Flag is per packet
         if (load_state)
            spec_match <= 1'b0;
         else if (accept_out)
            spec_match <= 1'b1;
         else if (eop && !enable)
            spec_match <= 1'b0;
         // At most one hit per packet, however many matches it held
         if (eop && enable)
            count <= count + COUNT_W'(spec_match);
      end
   end

   pattern_dfa #(
      .PATTERN (PATTERN)
   ) u_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

   // Load and commit belong to different phases of a packet
   a_load_eop_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(load_state && eop));

endmodule

// ==== packet_sequencer.sv ====
`timescale 1ns/1ps

module packet_sequencer
   import nids_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   // Byte input, valid/ready
   input  logic                 in_valid,
   output logic                 in_ready,
   input  logic [CHAR_W-1:0]    in_data,
   input  logic                 in_last,
   input  logic [STREAM_W-1:0]  in_stream_id,
   input  logic                 in_new_stream,
   input  logic [NUM_RULES-1:0] in_enable,
   // Broadcast to the rule counters
   output logic [CHAR_W-1:0]    char_in,
   output logic                 char_in_vld,
   output logic                 load_state,
   output logic                 eop,
   output logic [STREAM_W-1:0]  stream_id,
   output logic                 new_stream_id,
   output logic [NUM_RULES-1:0] rule_enable,
   // Result strobe
   output logic                 verdict_valid
);

   seq_state_t state_q;
   seq_state_t state_d;

   // Packet context latched from the first beat
   logic [STREAM_W-1:0]  stream_id_q;
   logic                 new_stream_q;
   logic [NUM_RULES-1:0] enable_q;

   // Beat moves on this edge
   logic                 beat;

   assign in_ready = (state_q == SEQ_SCAN);
   assign beat     = in_valid && in_ready;

   // Bytes go straight to the matchers
   assign char_in     = in_data;
   assign char_in_vld = beat;

   // Phase strobes decoded from the state register
   assign load_state = (state_q == SEQ_LOAD);
   assign eop        = (state_q == SEQ_EOP);

   assign stream_id     = stream_id_q;
   assign new_stream_id = new_stream_q;
   assign rule_enable   = enable_q;

   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         SEQ_IDLE:
            if (in_valid)
               state_d = SEQ_LOAD;
         SEQ_LOAD:
            state_d = SEQ_RESTORE;
         SEQ_RESTORE:
            state_d = SEQ_SCAN;
         SEQ_SCAN:
            // Gaps in in_valid just stretch the scan
            if (beat && in_last)
               state_d = SEQ_DRAIN;
         SEQ_DRAIN:
            state_d = SEQ_EOP;
         SEQ_EOP:
            state_d = SEQ_IDLE;
         default:
            state_d = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q       <= SEQ_IDLE;
         verdict_valid <= 1'b0;
      end
      else
      begin
         state_q       <= state_d;
         // Counts and flags are settled one cycle after eop
         verdict_valid <= (state_q == SEQ_EOP);
      end
   end

   // Source holds these for the whole packet, so grab them on the way out of idle
   always_ff @(posedge clk)
   begin
      if (state_q == SEQ_IDLE && in_valid)
      begin
         stream_id_q  <= in_stream_id;
         new_stream_q <= in_new_stream;
         enable_q     <= in_enable;
      end
   end

   // Ready opens only once the load and restore cycles have passed
   a_ready_after_restore: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(in_ready) |-> $past(load_state, 2));

   // Drain cycle sits between the last byte and the commit
   a_eop_after_last: assert property (@(posedge clk) disable iff (!rst_n)
      (beat && in_last) |-> ##2 eop);

endmodule

// ==== nntp_inspector_top.sv ====
`timescale 1ns/1ps

module nntp_inspector_top
   import nids_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   // Byte input
   input  logic                 in_valid,
   output logic                 in_ready,
   input  logic [CHAR_W-1:0]    in_data,
   input  logic                 in_last,
   input  logic [STREAM_W-1:0]  in_stream_id,
   input  logic                 in_new_stream,
   input  logic [NUM_RULES-1:0] in_enable,
   // Per-packet results
   output logic                 verdict_valid,
   output logic                 user_fired,
   output logic                 pass_fired,
   output logic [COUNT_W-1:0]   user_count,
   output logic [COUNT_W-1:0]   pass_count
);

   // Sequencer broadcast
   logic [CHAR_W-1:0]    char_in;
   logic                 char_in_vld;
   logic                 load_state;
   logic                 eop;
   logic [STREAM_W-1:0]  stream_id;
   logic                 new_stream_id;
   logic [NUM_RULES-1:0] rule_enable;

   packet_sequencer u_sequencer (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .in_data       (in_data),
      .in_last       (in_last),
      .in_stream_id  (in_stream_id),
      .in_new_stream (in_new_stream),
      .in_enable     (in_enable),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .load_state    (load_state),
      .eop           (eop),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .rule_enable   (rule_enable),
      .verdict_valid (verdict_valid)
   );

   // Enable bit 0 selects the USER rule
   stream_rule_counter #(
      .PATTERN (PAT_USER)
   ) u_rule_user (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .load_state    (load_state),
      .enable        (rule_enable[0]),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .count         (user_count),
      .fired         (user_fired)
   );

   // Enable bit 1 selects the PASS rule
   stream_rule_counter #(
      .PATTERN (PAT_PASS)
   ) u_rule_pass (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .load_state    (load_state),
      .enable        (rule_enable[1]),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .count         (pass_count),
      .fired         (pass_fired)
   );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk,
   output logic rst_n
);

   // Half of the 100 ns period
   localparam int HALF_NS = 50;
   // Rising edges with reset held low
   localparam int RESET_CYCLES = 16;

   initial
   begin
      clk = 1'b0;
      forever
         #(HALF_NS) clk = ~clk;
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES)
         @(posedge clk);
      // Released just after an edge, like every other DUT input
      #1;
      rst_n = 1'b1;
   end

endmodule

// ==== tb_nntp_inspector.sv ====
`timescale 1ns/1ps

module tb_nntp_inspector
   import nids_pkg::*;
();

   localparam int NUM_PKTS = 300;
   localparam int MAX_LEN  = 12;
   // Stream ids used by the random packets
   localparam int RAND_IDS = 8;
   // Longest packet, sequencing overhead and one idle cycle per byte, doubled, plus reset
   localparam longint WATCHDOG_NS = 64'(NUM_PKTS + 20) * (MAX_LEN + 4 + 12) * 100 * 2 + 1700;

   logic                 clk;
   logic                 rst_n;
   logic                 in_valid;
   logic                 in_ready;
   logic [CHAR_W-1:0]    in_data;
   logic                 in_last;
   logic [STREAM_W-1:0]  in_stream_id;
   logic                 in_new_stream;
   logic [NUM_RULES-1:0] in_enable;
   logic                 verdict_valid;
   logic                 user_fired;
   logic                 pass_fired;
   logic [COUNT_W-1:0]   user_count;
   logic [COUNT_W-1:0]   pass_count;

   integer      seed;
   int unsigned cyc;
   int unsigned verdict_cnt;
   int unsigned sent;
   // Position in the "USERPASS" walk that feeds biased bytes
   int          walk;

   // Packet being sent
   logic [7:0]  pkt_data [MAX_LEN];
   int          pkt_len;
   int          pkt_id;
   bit          pkt_new;
   logic [1:0]  pkt_enable;
   bit          pkt_gaps;

   // Reference model, rule 0 is USER and rule 1 is PASS
   string       pat [NUM_RULES];
   int          saved_state [NUM_RULES][NUM_STREAMS];
   int          model_count [NUM_RULES];
   bit          exp_fired [NUM_RULES];
   bit          stream_open [NUM_STREAMS];

   tb_clock_gen u_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   nntp_inspector_top u_nntp_inspector_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .in_data       (in_data),
      .in_last       (in_last),
      .in_stream_id  (in_stream_id),
      .in_new_stream (in_new_stream),
      .in_enable     (in_enable),
      .verdict_valid (verdict_valid),
      .user_fired    (user_fired),
      .pass_fired    (pass_fired),
      .user_count    (user_count),
      .pass_count    (pass_count)
   );

   // Cycle counter for latency checks
   always @(posedge clk)
   begin
      if (!rst_n)
         cyc <= 0;
      else
         cyc <= cyc + 1;
   end

   // Every verdict pulse is counted, sampled mid-cycle
   always @(negedge clk)
   begin
      if (rst_n && verdict_valid)
         verdict_cnt <= verdict_cnt + 1;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("MISMATCH at %0t ns: %s expected 0x%0h actual 0x%0h",
                  $time, name, expected, actual);
         $display("Verification failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Half of the bytes follow the signature walk, so matches show up often
   function automatic logic [7:0] random_byte();
      string letters = "USERPA";
      string walk_text = "USERPASS";
      int unsigned pick;
      pick = rand_below(8);
      if (pick < 4)
      begin
         walk = (walk + 1) % 8;
         return walk_text[walk];
      end
      else if (pick < 7)
         return letters[rand_below(6)];
      return 8'(rand_below(256));
   endfunction

   // Prefix length after one byte, a full match continues as an empty prefix
   function automatic int next_prefix(input int r, input int s, input logic [7:0] c);
      int base;
      base = (s == PAT_LEN) ? 0 : s;
      if (c == pat[r][base])
         return base + 1;
      else if (c == pat[r][0])
         return 1;
      return 0;
   endfunction

   // Expected flags, counts and saved states for the current packet
   task automatic model_packet();
      int s;
      bit hit;
      for (int r = 0; r < NUM_RULES; r++)
      begin
         s = pkt_new ? 0 : saved_state[r][pkt_id];
         hit = 1'b0;
         for (int i = 0; i < pkt_len; i++)
         begin
            s = next_prefix(r, s, pkt_data[i]);
            if (s == PAT_LEN)
               hit = 1'b1;
         end
         exp_fired[r] = hit && pkt_enable[r];
         // Disabled rule neither saves state nor counts
         if (pkt_enable[r])
         begin
            saved_state[r][pkt_id] = s;
            model_count[r] += int'(hit);
         end
      end
   endtask

   // Byte beats with valid/ready, ready sampled at the falling edge
   task automatic drive_packet();
      bit moved;
      for (int i = 0; i < pkt_len; i++)
      begin
         in_valid = 1'b1;
         in_data  = pkt_data[i];
         in_last  = (i == pkt_len - 1);
         moved = 1'b0;
         while (!moved)
         begin
            @(negedge clk);
            moved = in_ready;
            @(posedge clk);
            #1;
         end
         in_valid = 1'b0;
         in_last  = 1'b0;
         // Occasional idle cycle between bytes
         if (i < pkt_len - 1 && rand_below(4) == 0)
         begin
            pkt_gaps = 1'b1;
            @(posedge clk);
            #1;
         end
      end
   endtask

   task automatic run_packet();
      int unsigned start_cyc;
      // A stream is opened fresh with both rules on, so both memories hold it
      if (!stream_open[pkt_id])
      begin
         pkt_new = 1'b1;
         pkt_enable = 2'b11;
         stream_open[pkt_id] = 1'b1;
      end
      model_packet();
      in_stream_id  = STREAM_W'(pkt_id);
      in_new_stream = pkt_new;
      in_enable     = pkt_enable;
      pkt_gaps  = 1'b0;
      start_cyc = cyc;
      drive_packet();
      do
         @(negedge clk);
      while (!verdict_valid);
      // Leaves idle on the next edge, verdict N+4 edges after that
      if (!pkt_gaps)
         check_value("verdict latency", start_cyc + pkt_len + 5, cyc);
      check_value("user_fired", exp_fired[0], user_fired);
      check_value("pass_fired", exp_fired[1], pass_fired);
      check_value("user_count", model_count[0], user_count);
      check_value("pass_count", model_count[1], pass_count);
      sent++;
      @(posedge clk);
      #1;
      check_value("verdict count", sent, verdict_cnt);
   endtask

   task automatic send_directed(input int id, input bit is_new, input logic [1:0] en,
                                input string text);
      pkt_id     = id;
      pkt_new    = is_new;
      pkt_enable = en;
      pkt_len    = text.len();
      for (int i = 0; i < pkt_len; i++)
         pkt_data[i] = text[i];
      run_packet();
   endtask

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: no result after %0d ns, the DUT stopped responding", WATCHDOG_NS);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      seed          = 69;
      walk          = 0;
      sent          = 0;
      in_valid      = 1'b0;
      in_data       = '0;
      in_last       = 1'b0;
      in_stream_id  = '0;
      in_new_stream = 1'b0;
      in_enable     = '0;
      pat[0]        = "USER";
      pat[1]        = "PASS";
      model_count[0] = 0;
      model_count[1] = 0;

      @(posedge rst_n);
      @(posedge clk);
      #1;
      // Idle after reset, nothing ready until a byte is offered
      repeat (4)
      begin
         @(negedge clk);
         check_value("in_ready", 0, in_ready);
         check_value("verdict_valid", 0, verdict_valid);
      end
      check_value("user_count", 0, user_count);
      check_value("pass_count", 0, pass_count);
      check_value("user_fired", 0, user_fired);
      check_value("pass_fired", 0, pass_fired);
      @(posedge clk);
      #1;

      // Cleared state on the first load, "ER" alone is no match
      send_directed(3, 1'b1, 2'b11, "ER");
      // USER split over two packets of stream 3
      send_directed(3, 1'b1, 2'b11, "US");
      send_directed(3, 1'b0, 2'b11, "ER");
      // PASS prefix on stream 3 is not finished by stream 5
      send_directed(3, 1'b0, 2'b11, "PA");
      send_directed(5, 1'b1, 2'b11, "SS");
      send_directed(3, 1'b0, 2'b11, "SS");
      // New-stream flag drops the saved prefix
      send_directed(4, 1'b1, 2'b11, "PAS");
      send_directed(4, 1'b1, 2'b11, "S");
      // Prefix seen while USER was off is not kept
      send_directed(6, 1'b1, 2'b11, "XY");
      send_directed(6, 1'b0, 2'b10, "US");
      send_directed(6, 1'b0, 2'b11, "ER");

      for (int p = 0; p < NUM_PKTS; p++)
      begin
         pkt_len    = 1 + rand_below(MAX_LEN);
         pkt_id     = rand_below(RAND_IDS);
         pkt_new    = (rand_below(8) == 0);
         pkt_enable = 2'(rand_below(4));
         for (int i = 0; i < pkt_len; i++)
            pkt_data[i] = random_byte();
         run_packet();
      end

      $display("Verification passed");
      $finish;
   end

endmodule

// ==== sources.f ====
nids_pkg.sv
pattern_dfa.sv
stream_rule_counter.sv
packet_sequencer.sv
nntp_inspector_top.sv
tb_clock_gen.sv
tb_nntp_inspector.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_nntp_inspector
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build, run, and pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
